//--- hw/astro_cfg_pkg.sv
/*
  Game selection and DIP switch constants for the cabinet glue logic.
  Only Space Zap, Gorf and Robby Roto are decoded; other numbers select no game.
  Download numbers are 16-bit words, compared against the low byte of the stream.
*/

`default_nettype none

package astro_cfg_pkg;

	// ========================================
	// Selected game
	// ========================================

	// game_none leaves every switch row high and the audio mono
	typedef enum logic [1:0] {
		game_none       = 2'd0,
		game_space_zap  = 2'd1,
		game_gorf       = 2'd2,
		game_robby_roto = 2'd3
	} game_t;

	// Game numbers as sent by the loader
	localparam logic [15:0] game_num_space_zap  = 16'd3;
	localparam logic [15:0] game_num_gorf       = 16'd4;
	localparam logic [15:0] game_num_robby      = 16'd6;
	// Program 1 variant runs as plain Gorf
	localparam logic [15:0] game_num_gorf_prog1 = 16'd7;

	// ========================================
	// Download stream indices
	// ========================================

	localparam logic [7:0] dl_index_game = 8'd1;
	localparam logic [7:0] dl_index_dip  = 8'd254;

	// DIP byte address space, writes at or above this are dropped
	localparam int dip_count = 8;

	// DIP 0 bit positions
	localparam int dip_cabinet_bit = 0;
	localparam int dip_swap_bit    = 1;

endpackage

`default_nettype wire

//--- hw/astro_io_pkg.sv
/*
  Cabinet I/O types: joystick bit map, switch column codes, audio and lamps.
  Start and coin bits are taken from joystick 0 only.
  Audio samples are unsigned with silence at mid scale for the sample channels.
*/

`default_nettype none

package astro_io_pkg;

	// ========================================
	// Switch matrix
	// ========================================

	// DIP byte or switch row byte
	typedef logic [7:0] dip_t;
	// Column strobe from the CPU, one hot when valid
	typedef logic [7:0] col_t;

	localparam col_t col_0 = 8'h01;
	localparam col_t col_1 = 8'h02;
	localparam col_t col_2 = 8'h04;
	localparam col_t col_3 = 8'h08;

	// Joystick word, buttons active high
	typedef logic [15:0] joy_t;

	localparam int joy_right  = 0;
	localparam int joy_left   = 1;
	localparam int joy_down   = 2;
	localparam int joy_up     = 3;
	localparam int joy_fire   = 4;
	localparam int joy_start1 = 6;
	localparam int joy_start2 = 7;
	localparam int joy_coin   = 8;

	// ========================================
	// Audio and lamps
	// ========================================

	typedef logic [15:0] sample_t;

	// Lifts the sound chip to the sample silence level
	localparam sample_t cabinet_offset = 16'd16384;

	typedef logic [7:0] lamp_bank_t;
	typedef logic [2:0] lamp_addr_t;

	// clk_sys cycles per CPU tick
	localparam int cpu_tick_div = 4;

endpackage

`default_nettype wire

//--- hw/game_config.sv
/*
  Captures game number and DIP bytes 0, 2 and 3 from the download stream.
  Game is valid 2 cycles after its strobe, a DIP byte 1 cycle after.
  Only the low data byte is stored; DIP addresses of 8 or more are ignored.
*/

`timescale 1ns/1ps
`default_nettype none

module game_config
	import astro_cfg_pkg::*;
	import astro_io_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        reset,
	input  wire logic        dl_write,
	input  wire dip_t        dl_index,
	input  wire logic [24:0] dl_addr,
	input  wire logic [15:0] dl_data,
	output game_t            game,
	output dip_t             dip_0,
	output dip_t             dip_2,
	output dip_t             dip_3
);

	// Raw game number as downloaded
	logic [7:0] game_num;

	// Qualified write strobes
	logic game_wr;
	logic dip_wr;

	assign game_wr = dl_write && (dl_index == dl_index_game);
	assign dip_wr  = dl_write && (dl_index == dl_index_dip) && (dl_addr < 25'(dip_count));

	// ========================================
	// Game number and decode
	// ========================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_num <= 8'h00;
			game     <= game_none;
		end else begin
			if (game_wr)
				game_num <= dl_data[7:0];

			// Second stage decodes the number held in the first
			case ({8'h00, game_num})
				game_num_space_zap:  game <= game_space_zap;
				game_num_gorf:       game <= game_gorf;
				game_num_gorf_prog1: game <= game_gorf;
				game_num_robby:      game <= game_robby_roto;
				default:             game <= game_none;
			endcase
		end
	end

	// ========================================
	// DIP bytes
	// ========================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dip_0 <= 8'h00;
			dip_2 <= 8'h00;
			dip_3 <= 8'h00;
		end else if (dip_wr) begin
			// Bytes 1 and 4 to 7 have no reader
			case (dl_addr[2:0])
				3'd0:    dip_0 <= dl_data[7:0];
				3'd2:    dip_2 <= dl_data[7:0];
				3'd3:    dip_3 <= dl_data[7:0];
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/switch_matrix.sv
/*
  Switch-matrix responder. Combinational from col_select to row_data.
  Buttons read active low. Unknown columns and game_none read FF.
  The Gorf speech-busy bit reads 0; dip_0 is carried but not yet mapped.
*/

`timescale 1ns/1ps
`default_nettype none

module switch_matrix
	import astro_cfg_pkg::*;
	import astro_io_pkg::*;
(
	input  wire game_t game,
	input  wire dip_t  dip_0,
	input  wire dip_t  dip_2,
	input  wire dip_t  dip_3,
	input  wire joy_t  joystick_0,
	input  wire joy_t  joystick_1,
	input  wire col_t  col_select,
	output dip_t       row_data
);

	// Shared buttons, inverted to switch polarity
	logic start1_n;
	logic start2_n;
	logic coin_n;

	// Stick and fire per player, order fire,right,left,down,up
	logic [4:0] p1_n;
	logic [4:0] p2_n;

	// Row bytes per game and column
	dip_t sz_col0;
	dip_t sz_col1;
	dip_t sz_col2;
	dip_t gf_col0;
	dip_t gf_col1;
	dip_t gf_col2;
	dip_t rr_col0;
	dip_t rr_col1;
	dip_t rr_col2;

	assign start1_n = ~joystick_0[joy_start1];
	assign start2_n = ~joystick_0[joy_start2];
	assign coin_n   = ~joystick_0[joy_coin];

	assign p1_n = ~{joystick_0[joy_fire], joystick_0[joy_right], joystick_0[joy_left],
		joystick_0[joy_down], joystick_0[joy_up]};
	assign p2_n = ~{joystick_1[joy_fire], joystick_1[joy_right], joystick_1[joy_left],
		joystick_1[joy_down], joystick_1[joy_up]};

	// ========================================
	// Row layouts
	// ========================================

	// Space Zap
	assign sz_col0 = {2'b11, start2_n, start1_n, dip_2[1], 1'b1, coin_n, 1'b1};
	assign sz_col1 = {3'b111, p2_n};
	assign sz_col2 = {2'b11, dip_2[0], p1_n};

	// Gorf, bit 7 of col 1 and 2 is speech busy, always idle here
	assign gf_col0 = {dip_2[2], dip_2[0], start2_n, start1_n, 1'b1, dip_2[1], coin_n, 1'b1};
	assign gf_col1 = {3'b001, p2_n};
	assign gf_col2 = {3'b001, p1_n};

	// Robby Roto, a fixed high bit sits between fire and the stick
	assign rr_col0 = {1'b0, start2_n, start1_n, 1'b1, dip_2[1], 1'b1, coin_n, 1'b1};
	assign rr_col1 = {2'b11, p2_n[4], 1'b1, p2_n[3:0]};
	assign rr_col2 = {2'b11, p1_n[4], 1'b1, p1_n[3:0]};

	// ========================================
	// Column select
	// ========================================

	always_comb begin
		row_data = 8'hFF;
		case (game)
			game_space_zap: begin
				case (col_select)
					col_0:   row_data = sz_col0;
					col_1:   row_data = sz_col1;
					col_2:   row_data = sz_col2;
					col_3:   row_data = dip_3;
					default: row_data = 8'hFF;
				endcase
			end
			game_gorf: begin
				case (col_select)
					col_0:   row_data = gf_col0;
					col_1:   row_data = gf_col1;
					col_2:   row_data = gf_col2;
					col_3:   row_data = dip_3;
					default: row_data = 8'hFF;
				endcase
			end
			game_robby_roto: begin
				case (col_select)
					col_0:   row_data = rr_col0;
					col_1:   row_data = rr_col1;
					col_2:   row_data = rr_col2;
					col_3:   row_data = dip_3;
					default: row_data = 8'hFF;
				endcase
			end
			// No game selected, nothing pressed
			default: row_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/audio_mixer.sv
/*
  Per-game audio mix, combinational. Samples are unsigned 16 bit.
  Gorf halves both sources so the sum never overflows.
  Cabinet mode clips the offset sound chip at FFFF. DIP 0 bit 1 swaps channels.
*/

`timescale 1ns/1ps
`default_nettype none

module audio_mixer
	import astro_cfg_pkg::*;
	import astro_io_pkg::*;
(
	input  wire game_t   game,
	input  wire dip_t    dip_0,
	input  wire sample_t chip_left,
	input  wire sample_t chip_right,
	input  wire sample_t sample_left,
	input  wire sample_t sample_right,
	input  wire logic    speech_select,
	output sample_t      audio_left,
	output sample_t      audio_right
);

	// Gorf mix of halved chip and sample stays at or below FFFE
	sample_t gorf_sum_l;
	sample_t gorf_sum_r;

	// Cabinet lower speaker path
	logic [16:0] cab_sum;
	sample_t     cab_sat;
	logic        gorf_cabinet;

	// Mix before the swap
	sample_t mix_l;
	sample_t mix_r;

	assign gorf_sum_l = {1'b0, chip_left[15:1]} + {1'b0, sample_left[15:1]};
	assign gorf_sum_r = {1'b0, chip_right[15:1]} + {1'b0, sample_right[15:1]};

	// ========================================
	// Gorf cabinet routing
	// ========================================

	// Upper speaker gets chip right, lower gets chip left or speech
	assign gorf_cabinet = (game == game_gorf) && dip_0[dip_cabinet_bit];

	// Chip silence is 0 and is offset towards sample silence
	assign cab_sum = {1'b0, chip_left} + {1'b0, cabinet_offset};
	assign cab_sat = cab_sum[16] ? 16'hFFFF : cab_sum[15:0];

	// ========================================
	// Game mix
	// ========================================

	always_comb begin
		mix_l = chip_left;
		mix_r = chip_left;
		case (game)
			game_gorf: begin
				if (gorf_cabinet) begin
					mix_r = chip_right;
					mix_l = speech_select ? {1'b0, sample_left[15:1]} : cab_sat;
				end else begin
					mix_l = gorf_sum_l;
					mix_r = gorf_sum_r;
				end
			end
			// Two sound chips in true stereo
			game_robby_roto: begin
				mix_l = chip_left;
				mix_r = chip_right;
			end
			// Space Zap and no game are mono from the left chip
			default: begin
				mix_l = chip_left;
				mix_r = chip_left;
			end
		endcase
	end

	// Channel swap applies to every game
	assign audio_left  = dip_0[dip_swap_bit] ? mix_r : mix_l;
	assign audio_right = dip_0[dip_swap_bit] ? mix_l : mix_r;

endmodule

`default_nettype wire

//--- hw/lamp_serializer.sv
/*
  Gorf lamp serializer for an external addressable latch.
  One changed bit per CPU tick pair, lowest index first, latest lamp_state wins.
  lamp_write is active low for one tick (4 clk_sys cycles). No back-pressure.
  New writes start only while Gorf is selected; a running pulse always ends.
*/

`timescale 1ns/1ps
`default_nettype none

module lamp_serializer
	import astro_cfg_pkg::*;
	import astro_io_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire game_t      game,
	input  wire lamp_bank_t lamp_state,
	output lamp_addr_t      lamp_address,
	output logic            lamp_data,
	output logic            lamp_write
);

	localparam int tick_w = $clog2(cpu_tick_div);

	typedef enum logic {
		lamp_idle   = 1'b0,
		lamp_strobe = 1'b1
	} lamp_state_t;

	lamp_state_t state;

	// CPU rate divider
	logic [tick_w-1:0] tick_cnt;
	logic              tick;

	// What the latch currently holds, as far as we know
	lamp_bank_t image;
	lamp_bank_t diff;

	// Lowest differing bit
	lamp_addr_t low_idx;

	// ========================================
	// Tick generator
	// ========================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign tick = (tick_cnt == tick_w'(cpu_tick_div - 1));

	// ========================================
	// Change detect
	// ========================================

	assign diff = image ^ lamp_state;

	always_comb begin
		low_idx = '0;
		// Walk down so the lowest set bit is the last one taken
		for (int i = 7; i >= 0; i--) begin
			if (diff[i])
				low_idx = lamp_addr_t'(i);
		end
	end

	// ========================================
	// Write FSM
	// ========================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state        <= lamp_idle;
			image        <= 8'hFF;
			lamp_address <= '0;
			lamp_data    <= 1'b0;
		end else if (tick) begin
			case (state)
				lamp_idle: begin
					if ((game == game_gorf) && (diff != 8'h00)) begin
						lamp_address   <= low_idx;
						lamp_data      <= lamp_state[low_idx];
						image[low_idx] <= lamp_state[low_idx];
						state          <= lamp_strobe;
					end
				end
				// Release the strobe, latch captures on the rising edge
				lamp_strobe: state <= lamp_idle;
				default:     state <= lamp_idle;
			endcase
		end
	end

	// Active low latch enable
	assign lamp_write = (state != lamp_strobe);

endmodule

`default_nettype wire

//--- hw/astro_glue_top.sv
/*
  Cabinet glue top level. All blocks run on clk_sys with async active-high reset.
  Download stream uses the low data byte only.
  Switch matrix and audio paths are combinational from their inputs.
*/

`timescale 1ns/1ps
`default_nettype none

module astro_glue_top
	import astro_cfg_pkg::*;
	import astro_io_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        reset,

	// Download stream
	input  wire logic        dl_write,
	input  wire dip_t        dl_index,
	input  wire logic [24:0] dl_addr,
	input  wire logic [15:0] dl_data,

	// Switch matrix
	input  wire joy_t        joystick_0,
	input  wire joy_t        joystick_1,
	input  wire col_t        col_select,
	output dip_t             row_data,

	// Audio
	input  wire sample_t     chip_left,
	input  wire sample_t     chip_right,
	input  wire sample_t     sample_left,
	input  wire sample_t     sample_right,
	input  wire logic        speech_select,
	output sample_t          audio_left,
	output sample_t          audio_right,

	// Gorf lamps
	input  wire lamp_bank_t  lamp_state,
	output lamp_addr_t       lamp_address,
	output logic             lamp_data,
	output logic             lamp_write
);

	// Configuration shared by all blocks
	game_t game;
	dip_t  dip_0;
	dip_t  dip_2;
	dip_t  dip_3;

	game_config i_game_config (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_write (dl_write),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip_0    (dip_0),
		.dip_2    (dip_2),
		.dip_3    (dip_3)
	);

	switch_matrix i_switch_matrix (
		.game       (game),
		.dip_0      (dip_0),
		.dip_2      (dip_2),
		.dip_3      (dip_3),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.col_select (col_select),
		.row_data   (row_data)
	);

	audio_mixer i_audio_mixer (
		.game          (game),
		.dip_0         (dip_0),
		.chip_left     (chip_left),
		.chip_right    (chip_right),
		.sample_left   (sample_left),
		.sample_right  (sample_right),
		.speech_select (speech_select),
		.audio_left    (audio_left),
		.audio_right   (audio_right)
	);

	lamp_serializer i_lamp_serializer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.game         (game),
		.lamp_state   (lamp_state),
		.lamp_address (lamp_address),
		.lamp_data    (lamp_data),
		.lamp_write   (lamp_write)
	);

endmodule

`default_nettype wire

//--- sim/astro_glue_sva.sv
/*
  Concurrent checks on the lamp latch port and the switch-matrix response.
  Bound into the top level, where both port groups meet clk_sys.
  sva_errors counts failures so the testbench summary can include them.
*/

`timescale 1ns/1ps
`default_nettype none

module astro_glue_sva
	import astro_io_pkg::*;
(
	input wire logic       clk_sys,
	input wire logic       reset,
	input wire lamp_addr_t lamp_address,
	input wire logic       lamp_data,
	input wire logic       lamp_write,
	input wire col_t       col_select,
	input wire dip_t       row_data
);

	int sva_errors = 0;

	// One of the four valid column codes
	logic strobe_col;

	assign strobe_col = (col_select == col_0) || (col_select == col_1) ||
		(col_select == col_2) || (col_select == col_3);

	// Latch enable pulse spans one CPU tick
	lamp_pulse_len: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(lamp_write) |=> !lamp_write [*3] ##1 lamp_write)
	else begin
		$error("lamp_write low pulse is not 4 cycles long");
		sva_errors++;
	end

	// Latch sees steady address and data while enabled
	lamp_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(!lamp_write && !$past(lamp_write)) |-> ($stable(lamp_address) && $stable(lamp_data)))
	else begin
		$error("lamp address or data changed during the write pulse");
		sva_errors++;
	end

	// No switch closed outside the strobed columns
	row_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!strobe_col |-> (row_data == 8'hFF))
	else begin
		$error("row_data not FF for a non-strobe column");
		sva_errors++;
	end

endmodule

bind astro_glue_top astro_glue_sva i_glue_sva (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.lamp_address (lamp_address),
	.lamp_data    (lamp_data),
	.lamp_write   (lamp_write),
	.col_select   (col_select),
	.row_data     (row_data)
);

`default_nettype wire

//--- sim/astro_glue_tb.sv
/*
  Testbench for the cabinet glue top level. Random stimulus, seed 32'h89.
  Inputs change on the falling clock edge, outputs are read one falling edge later.
  A second reset near the end checks that the lamp port stays idle.
*/

`timescale 1ns/1ps
`default_nettype none

module astro_glue_tb
	import astro_cfg_pkg::*;
	import astro_io_pkg::*;
();

	// ========================================
	// Test lengths and cycle budget
	// ========================================

	localparam int n_cfg   = 60;
	localparam int n_row   = 300;
	localparam int n_audio = 200;
	localparam int n_lamp  = 40;

	// Margins cover downloads, game decode and the lamp drain
	localparam int cfg_cycles   = n_cfg * 8;
	localparam int row_cycles   = 4 * n_row + 400;
	localparam int audio_cycles = 4 * n_audio * 4;
	localparam int lamp_cycles  = n_lamp * 100 + 200;
	localparam int idle_cycles  = 600;
	localparam int timeout_cycles =
		2 * (cfg_cycles + row_cycles + audio_cycles + lamp_cycles + idle_cycles);

	// DUT ports
	logic        clk_sys;
	logic        reset;
	logic        dl_write;
	dip_t        dl_index;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	joy_t        joystick_0;
	joy_t        joystick_1;
	col_t        col_select;
	dip_t        row_data;
	sample_t     chip_left;
	sample_t     chip_right;
	sample_t     sample_left;
	sample_t     sample_right;
	logic        speech_select;
	sample_t     audio_left;
	sample_t     audio_right;
	lamp_bank_t  lamp_state;
	lamp_addr_t  lamp_address;
	logic        lamp_data;
	logic        lamp_write;

	// Reference model of the configuration registers
	game_t m_game;
	dip_t  m_dip0;
	dip_t  m_dip2;
	dip_t  m_dip3;

	// Lamp latch as rebuilt from the observed write pulses
	lamp_bank_t m_image = 8'hFF;
	lamp_bank_t lamp_at_edge;
	logic       lamp_write_prev = 1'b1;

	integer seed;
	int     checks = 0;
	int     errors = 0;
	int     lamp_writes = 0;
	int     cycle_count = 0;

	astro_glue_top i_astro_glue_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= timeout_cycles);
		$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
		$display("Regression failed");
		$finish;
	end

	// ========================================
	// Model functions
	// ========================================

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic game_t decode_game(input logic [7:0] num);
		logic [15:0] word;
		word = {8'h00, num};
		if (word == game_num_space_zap)
			return game_space_zap;
		if (word == game_num_gorf || word == game_num_gorf_prog1)
			return game_gorf;
		if (word == game_num_robby)
			return game_robby_roto;
		return game_none;
	endfunction

	// Row byte from the switch table with buttons active low
	function automatic dip_t expected_row(input game_t g, input joy_t j0, input joy_t j1,
		input col_t c);
		logic       s1;
		logic       s2;
		logic       cn;
		logic [4:0] p1;
		logic [4:0] p2;
		s1 = ~j0[joy_start1];
		s2 = ~j0[joy_start2];
		cn = ~j0[joy_coin];
		p1 = ~{j0[joy_fire], j0[joy_right], j0[joy_left], j0[joy_down], j0[joy_up]};
		p2 = ~{j1[joy_fire], j1[joy_right], j1[joy_left], j1[joy_down], j1[joy_up]};
		if (g == game_none)
			return 8'hFF;
		if (c == col_3)
			return m_dip3;
		if (c != col_0 && c != col_1 && c != col_2)
			return 8'hFF;
		case (g)
			game_space_zap: begin
				if (c == col_0)
					return {2'b11, s2, s1, m_dip2[1], 1'b1, cn, 1'b1};
				if (c == col_1)
					return {3'b111, p2};
				return {2'b11, m_dip2[0], p1};
			end
			game_gorf: begin
				if (c == col_0)
					return {m_dip2[2], m_dip2[0], s2, s1, 1'b1, m_dip2[1], cn, 1'b1};
				// Speech busy reads 0
				if (c == col_1)
					return {3'b001, p2};
				return {3'b001, p1};
			end
			default: begin
				if (c == col_0)
					return {1'b0, s2, s1, 1'b1, m_dip2[1], 1'b1, cn, 1'b1};
				if (c == col_1)
					return {2'b11, p2[4], 1'b1, p2[3:0]};
				return {2'b11, p1[4], 1'b1, p1[3:0]};
			end
		endcase
	endfunction

	// Left channel in the upper half and right in the lower
	function automatic logic [31:0] expected_audio(input sample_t cl, input sample_t cr,
		input sample_t sl, input sample_t sr, input logic spk);
		int      cab;
		sample_t l;
		sample_t r;
		sample_t t;
		l = cl;
		r = cl;
		if (m_game == game_robby_roto) begin
			r = cr;
		end else if (m_game == game_gorf) begin
			if (m_dip0[dip_cabinet_bit]) begin
				r = cr;
				cab = int'(cl) + int'(cabinet_offset);
				if (spk)
					l = sl / 2;
				else
					l = (cab > 65535) ? 16'hFFFF : sample_t'(cab);
			end else begin
				l = cl / 2 + sl / 2;
				r = cr / 2 + sr / 2;
			end
		end
		if (m_dip0[dip_swap_bit]) begin
			t = l;
			l = r;
			r = t;
		end
		return {l, r};
	endfunction

	function automatic int lowest_set_bit(input lamp_bank_t v);
		for (int i = 0; i < 8; i++)
			if (v[i])
				return i;
		return -1;
	endfunction

	function automatic col_t random_strobe();
		int k;
		k = next_random() % 4;
		return col_t'(8'h01 << k);
	endfunction

	function automatic col_t random_non_strobe();
		col_t c;
		do
			c = col_t'(next_random());
		while (c == col_0 || c == col_1 || c == col_2 || c == col_3);
		return c;
	endfunction

	// ========================================
	// Checks and drivers
	// ========================================

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int c0, input int e0);
		$display("%-16s checks %0d, errors %0d", name, checks - c0, errors - e0);
	endtask

	// One-cycle strobe; the model follows the write at once
	task automatic download(input dip_t idx, input logic [24:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		dl_write = 1'b1;
		dl_index = idx;
		dl_addr  = addr;
		dl_data  = data;
		@(negedge clk_sys);
		dl_write = 1'b0;
		if (idx == dl_index_game)
			m_game = decode_game(data[7:0]);
		if (idx == dl_index_dip && addr < 25'd8) begin
			case (addr[2:0])
				3'd0: m_dip0 = data[7:0];
				3'd2: m_dip2 = data[7:0];
				3'd3: m_dip3 = data[7:0];
				default: ;
			endcase
		end
	endtask

	task automatic select_game(input game_t g);
		logic [7:0] num;
		case (g)
			game_space_zap:  num = game_num_space_zap[7:0];
			game_robby_roto: num = game_num_robby[7:0];
			game_gorf: begin
				if (next_random() % 2)
					num = game_num_gorf_prog1[7:0];
				else
					num = game_num_gorf[7:0];
			end
			default: begin
				num = 8'(next_random());
				while (decode_game(num) != game_none)
					num = 8'(next_random());
			end
		endcase
		download(dl_index_game, 25'(next_random()), {8'(next_random()), num});
		// Decode stage
		@(negedge clk_sys);
	endtask

	// Called on a falling edge and returns on the next one
	task automatic drive_row_and_check(input col_t col);
		joystick_0 = joy_t'(next_random());
		joystick_1 = joy_t'(next_random());
		col_select = col;
		@(negedge clk_sys);
		check_value("row_data", row_data, expected_row(m_game, joystick_0, joystick_1, col));
	endtask

	// ========================================
	// Lamp monitor
	// ========================================

	// Value the serializer compared at the last rising edge
	always @(posedge clk_sys)
		lamp_at_edge <= lamp_state;

	always @(negedge clk_sys) begin : lamp_monitor
		int low;
		if (reset) begin
			m_image = 8'hFF;
			lamp_write_prev = 1'b1;
		end else begin
			if (lamp_write_prev && !lamp_write) begin
				lamp_writes++;
				low = lowest_set_bit(m_image ^ lamp_at_edge);
				assert (low >= 0) else begin
					$display("Lamp write started at %0t ns with no changed lamp", $time);
					errors++;
				end
				if (low >= 0) begin
					check_value("lamp_address", lamp_address, low);
					check_value("lamp_data", lamp_data, lamp_at_edge[low]);
				end
				m_image[lamp_address] = lamp_data;
			end
			lamp_write_prev = lamp_write;
		end
	end

	// ========================================
	// Tests
	// ========================================

	task automatic config_capture();
		int          c0;
		int          e0;
		int          r;
		dip_t        idx;
		logic [24:0] addr;
		logic [15:0] data;
		c0 = checks;
		e0 = errors;
		for (int i = 0; i < n_cfg; i++) begin
			r = next_random() % 8;
			data = 16'(next_random());
			addr = 25'(next_random() % 16);
			if (r < 3) begin
				idx = dl_index_game;
				// Mostly known numbers and otherwise an unknown one
				case (next_random() % 8)
					0: data[7:0] = 8'd3;
					1: data[7:0] = 8'd4;
					2: data[7:0] = 8'd6;
					3: data[7:0] = 8'd7;
					default: ;
				endcase
			end else if (r < 7) begin
				idx = dl_index_dip;
				if (r == 6)
					addr = 25'(next_random());
			end else begin
				idx = dip_t'(next_random());
			end
			download(idx, addr, data);
			drive_row_and_check(col_3);
			drive_row_and_check(col_0);
		end
		report_test("config", c0, e0);
	endtask

	task automatic switch_table();
		int    c0;
		int    e0;
		game_t kept[3];
		c0 = checks;
		e0 = errors;
		kept = '{game_space_zap, game_gorf, game_robby_roto};
		for (int g = 0; g < 3; g++) begin
			select_game(kept[g]);
			for (int i = 0; i < n_row; i++) begin
				if (i % 50 == 0) begin
					download(dl_index_dip, 25'd2, 16'(next_random()));
					download(dl_index_dip, 25'd3, 16'(next_random()));
				end
				drive_row_and_check(random_strobe());
			end
		end
		report_test("switch_matrix", c0, e0);
	endtask

	task automatic idle_rows();
		int    c0;
		int    e0;
		game_t kept[3];
		c0 = checks;
		e0 = errors;
		kept = '{game_space_zap, game_gorf, game_robby_roto};
		select_game(game_none);
		for (int i = 0; i < 100; i++) begin
			if (next_random() % 2)
				drive_row_and_check(random_strobe());
			else
				drive_row_and_check(col_t'(next_random()));
		end
		for (int g = 0; g < 3; g++) begin
			select_game(kept[g]);
			for (int i = 0; i < 50; i++)
				drive_row_and_check(random_non_strobe());
		end
		report_test("unselected", c0, e0);
	endtask

	task automatic audio_mix();
		int          c0;
		int          e0;
		logic [31:0] exp;
		game_t       all_games[4];
		c0 = checks;
		e0 = errors;
		all_games = '{game_none, game_space_zap, game_gorf, game_robby_roto};
		for (int g = 0; g < 4; g++) begin
			select_game(all_games[g]);
			for (int i = 0; i < n_audio; i++) begin
				// Cabinet and swap bits come with the random DIP 0
				download(dl_index_dip, 25'd0, 16'(next_random()));
				case (next_random() % 4)
					0: chip_left = {2'b11, 14'(next_random())};
					1: chip_left = {2'b10, 14'(next_random())};
					default: chip_left = sample_t'(next_random());
				endcase
				chip_right    = sample_t'(next_random());
				sample_left   = sample_t'(next_random());
				sample_right  = sample_t'(next_random());
				speech_select = next_random() % 2;
				@(negedge clk_sys);
				exp = expected_audio(chip_left, chip_right, sample_left, sample_right,
					speech_select);
				check_value("audio_left", audio_left, exp[31:16]);
				check_value("audio_right", audio_right, exp[15:0]);
			end
		end
		report_test("audio", c0, e0);
	endtask

	task automatic lamp_changes();
		int c0;
		int e0;
		int w0;
		c0 = checks;
		e0 = errors;
		w0 = lamp_writes;
		select_game(game_gorf);
		for (int i = 0; i < n_lamp; i++) begin
			lamp_state = lamp_bank_t'(next_random());
			repeat (next_random() % 96)
				@(negedge clk_sys);
		end
		// Drain takes at most 8 writes of 8 cycles
		for (int k = 0; k < 100 && m_image != lamp_state; k++)
			@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("lamp image", m_image, lamp_state);
		assert (lamp_writes > w0) else begin
			$display("No lamp write was seen while Gorf was selected");
			errors++;
		end
		report_test("lamps", c0, e0);
	endtask

	task automatic lamp_quiet();
		int c0;
		int e0;
		c0 = checks;
		e0 = errors;
		reset  = 1'b1;
		m_game = game_none;
		m_dip0 = 8'h00;
		m_dip2 = 8'h00;
		m_dip3 = 8'h00;
		repeat (16) begin
			@(negedge clk_sys);
			check_value("lamp_write in reset", lamp_write, 1'b1);
		end
		reset = 1'b0;
		drive_row_and_check(random_strobe());
		for (int i = 0; i < 200; i++) begin
			if (i % 8 == 0)
				lamp_state = lamp_bank_t'(next_random());
			@(negedge clk_sys);
			check_value("lamp_write, no game", lamp_write, 1'b1);
		end
		select_game(game_space_zap);
		repeat (100) begin
			lamp_state = lamp_bank_t'(next_random());
			@(negedge clk_sys);
			check_value("lamp_write, Space Zap", lamp_write, 1'b1);
		end
		report_test("lamp_idle", c0, e0);
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		int sva_fails;
		seed          = 32'h89;
		reset         = 1'b1;
		dl_write      = 1'b0;
		dl_index      = 8'h00;
		dl_addr       = '0;
		dl_data       = 16'h0000;
		joystick_0    = 16'h0000;
		joystick_1    = 16'h0000;
		col_select    = 8'h00;
		chip_left     = 16'h0000;
		chip_right    = 16'h0000;
		sample_left   = 16'h0000;
		sample_right  = 16'h0000;
		speech_select = 1'b0;
		lamp_state    = 8'hFF;
		m_game        = game_none;
		m_dip0        = 8'h00;
		m_dip2        = 8'h00;
		m_dip3        = 8'h00;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		config_capture();
		switch_table();
		idle_rows();
		audio_mix();
		lamp_changes();
		lamp_quiet();

		sva_fails = i_astro_glue_top.i_glue_sva.sva_errors;
		$display("Total: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- astro_glue.f
hw/astro_cfg_pkg.sv
hw/astro_io_pkg.sv
hw/game_config.sv
hw/switch_matrix.sv
hw/audio_mixer.sv
hw/lamp_serializer.sv
hw/astro_glue_top.sv
sim/astro_glue_sva.sv
sim/astro_glue_tb.sv
